// File: design/heap_pkg.sv
`default_nettype none

package heap_pkg;

  localparam int unsigned DATA_W = 32;

  // bytes a header takes in front of its payload
  localparam logic [DATA_W-1:0] BLOCK_HEADER_SIZE = 'd16;
  localparam logic [DATA_W-1:0] MIN_ALLOC_SIZE    = 'd32;  // smallest leftover worth a split

  // fixed head of the free list, a next_addr of 0 ends it
  localparam logic [DATA_W-1:0] HEAD_ADDR = 'h10;

  typedef struct packed {
    logic [DATA_W-1:0] addr;
    logic [DATA_W-1:0] size;
    logic [DATA_W-1:0] next_addr;
  } header_t;

  typedef enum logic [2:0] {
    LOCK,
    UNLOCK,
    LOAD,
    EDIT_NEXT_ADDR,
    EDIT_SIZE_AND_NEXT_ADDR
  } lsu_op_e;

  // core to lsu
  typedef struct packed {
    logic    val;
    lsu_op_e lsu_op;
    header_t header;
  } header_req_t;

  // lsu to core, header only meaningful for LOAD
  typedef struct packed {
    logic    val;
    header_t header;
  } header_rsp_t;

endpackage

`default_nettype wire

// File: design/list_walker.sv
`timescale 1ns/1ns
`default_nettype none

module list_walker
  import heap_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_valid_i,
  input  logic              is_alloc_i,
  input  logic [DATA_W-1:0] size_i,
  input  logic [DATA_W-1:0] addr_i,
  output logic              ready_o,
  input  logic              lsu_ready_i,
  input  header_rsp_t       lsu_rsp_i,
  output header_req_t       lsu_req_o,
  output logic              clear_o,
  output logic              visit_o,
  output header_t           node_o,
  output header_t           pred_o,
  output logic [DATA_W-1:0] req_size_o,
  output logic [DATA_W-1:0] free_addr_o,
  input  logic              fit_found_i,
  input  logic              fit_split_i,
  input  header_t           fit_alloc_hdr_i,
  input  header_t           fit_split_hdr_i,
  input  header_t           fit_link_hdr_i,
  input  logic              slot_hit_i,
  input  header_t           slot_new_hdr_i,
  input  header_t           slot_link_hdr_i
);

  typedef enum logic [3:0] {
    S_IDLE,
    S_LOCK,
    S_LOAD,
    S_WAIT,
    S_VISIT,
    S_DECIDE,
    S_WR_ALLOC,
    S_WR_SPLIT,
    S_WR_NEW,
    S_WR_LINK,
    S_UNLOCK
  } state_e;

  state_e            state_q, state_d;
  state_e            after_q, after_d;  // where to go once the lsu answers
  logic              is_alloc_q;
  logic [DATA_W-1:0] size_q, free_addr_q;
  logic [DATA_W-1:0] load_addr_q;
  header_t           node_q, pred_q;
  header_t           link_hdr;
  logic              take, walk_on;

  assign take    = (state_q == S_IDLE) && req_valid_i;
  assign walk_on = (state_q == S_DECIDE) && (state_d == S_LOAD);

  assign ready_o     = (state_q == S_IDLE);
  assign clear_o     = take;
  assign visit_o     = (state_q == S_VISIT);
  assign node_o      = node_q;
  assign pred_o      = pred_q;
  assign req_size_o  = size_q;
  assign free_addr_o = free_addr_q;

  assign link_hdr = is_alloc_q ? fit_link_hdr_i : slot_link_hdr_i;

  // request only depends on state and held headers, so it stays put under back-pressure
  always_comb begin
    lsu_req_o     = '0;
    lsu_req_o.val = 1'b1;
    unique case (state_q)
      S_LOCK: lsu_req_o.lsu_op = LOCK;
      S_LOAD: begin
        lsu_req_o.lsu_op      = LOAD;
        lsu_req_o.header.addr = load_addr_q;
      end
      S_WR_ALLOC: begin
        lsu_req_o.lsu_op = EDIT_SIZE_AND_NEXT_ADDR;
        lsu_req_o.header = fit_alloc_hdr_i;
      end
      S_WR_SPLIT: begin
        lsu_req_o.lsu_op = EDIT_SIZE_AND_NEXT_ADDR;  // creates the leftover block
        lsu_req_o.header = fit_split_hdr_i;
      end
      S_WR_NEW: begin
        lsu_req_o.lsu_op = EDIT_NEXT_ADDR;  // freed block keeps its size
        lsu_req_o.header = slot_new_hdr_i;
      end
      S_WR_LINK: begin
        lsu_req_o.lsu_op = EDIT_NEXT_ADDR;
        lsu_req_o.header = link_hdr;
      end
      S_UNLOCK: lsu_req_o.lsu_op = UNLOCK;
      default:  lsu_req_o.val = 1'b0;
    endcase
  end

  always_comb begin
    state_d = state_q;
    after_d = after_q;
    if (lsu_req_o.val && lsu_ready_i) begin
      state_d = S_WAIT;
      unique case (state_q)
        S_LOCK:     after_d = S_LOAD;
        S_LOAD:     after_d = S_VISIT;
        S_WR_ALLOC: after_d = fit_split_i ? S_WR_SPLIT : S_WR_LINK;
        S_WR_SPLIT: after_d = S_WR_LINK;
        S_WR_NEW:   after_d = S_WR_LINK;
        S_WR_LINK:  after_d = S_UNLOCK;
        default:    after_d = S_IDLE;  // unlock
      endcase
    end else begin
      unique case (state_q)
        S_IDLE: begin
          if (req_valid_i) state_d = S_LOCK;
        end
        S_WAIT: begin
          if (lsu_rsp_i.val) state_d = after_q;
        end
        S_VISIT: state_d = S_DECIDE;  // helpers register the node here
        S_DECIDE: begin
          if (!is_alloc_q && slot_hit_i) begin
            state_d = S_WR_NEW;
          end else if (node_q.next_addr != '0) begin
            state_d = S_LOAD;
          end else if (is_alloc_q && fit_found_i) begin
            state_d = S_WR_ALLOC;
          end else begin
            state_d = S_UNLOCK;  // nothing fits, leave the list alone
          end
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= S_IDLE;
      after_q <= S_IDLE;
    end else begin
      state_q <= state_d;
      after_q <= after_d;
    end
  end

  // request fields and walk position
  always_ff @(posedge clk_i) begin
    if (take) begin
      is_alloc_q  <= is_alloc_i;
      size_q      <= size_i;
      free_addr_q <= addr_i;
      load_addr_q <= HEAD_ADDR;
      pred_q      <= '0;
    end
    if (state_q == S_WAIT && lsu_rsp_i.val && after_q == S_VISIT) begin
      node_q <= lsu_rsp_i.header;
    end
    if (walk_on) begin
      pred_q      <= node_q;
      load_addr_q <= node_q.next_addr;
    end
  end

  a_req_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    lsu_req_o.val && !lsu_ready_i |=> $stable(lsu_req_o));

endmodule

`default_nettype wire

// File: design/best_fit_tracker.sv
`timescale 1ns/1ns
`default_nettype none

module best_fit_tracker
  import heap_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              clear_i,
  input  logic              visit_i,
  input  header_t           node_i,
  input  header_t           pred_i,
  input  logic [DATA_W-1:0] req_size_i,
  output logic              found_o,
  output logic              do_split_o,
  output header_t           alloc_hdr_o,
  output header_t           split_hdr_o,
  output header_t           link_hdr_o
);

  header_t           best_q;
  header_t           best_pred_q;  // header whose next points at best_q
  logic              found_q;
  logic [DATA_W-1:0] node_left, best_left;
  logic [DATA_W-1:0] split_addr;
  logic              fits, better;

  assign node_left = node_i.size - req_size_i;
  assign best_left = best_q.size - req_size_i;
  assign fits      = node_i.size >= req_size_i;
  // strict compare, so a tie keeps the earlier block
  assign better    = fits && (!found_q || node_left < best_left);

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      found_q <= 1'b0;
    end else if (clear_i) begin
      found_q <= 1'b0;
    end else if (visit_i && better) begin
      found_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (visit_i && better) begin
      best_q      <= node_i;
      best_pred_q <= pred_i;
    end
  end

  assign found_o    = found_q;
  assign do_split_o = found_q && (best_left >= MIN_ALLOC_SIZE);
  assign split_addr = best_q.addr + BLOCK_HEADER_SIZE + req_size_i;

  always_comb begin
    alloc_hdr_o.addr      = best_q.addr;
    alloc_hdr_o.size      = req_size_i;
    alloc_hdr_o.next_addr = '0;  // taken block leaves the list

    // leftover becomes a block of its own behind the allocation
    split_hdr_o.addr      = split_addr;
    split_hdr_o.size      = best_left - BLOCK_HEADER_SIZE;
    split_hdr_o.next_addr = best_q.next_addr;

    link_hdr_o           = best_pred_q;
    link_hdr_o.next_addr = do_split_o ? split_addr : best_q.next_addr;
  end

  // req_size_i comes from the walker and must hold for the whole walk
  a_best_fits : assert property (@(posedge clk_i) disable iff (!rst_ni)
    found_o |-> best_q.size >= req_size_i);

endmodule

`default_nettype wire

// File: design/free_slot_finder.sv
`timescale 1ns/1ns
`default_nettype none

module free_slot_finder
  import heap_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              clear_i,
  input  logic              visit_i,
  input  header_t           node_i,
  input  logic [DATA_W-1:0] free_addr_i,
  output logic              hit_o,
  output header_t           new_hdr_o,
  output header_t           link_hdr_o
);

  header_t new_q, link_q;
  logic    hit_q;
  logic    in_range;

  // freed block goes after a node it sits behind, before that node's successor
  assign in_range = (node_i.addr < free_addr_i) &&
                    ((node_i.next_addr == '0) || (free_addr_i < node_i.next_addr));

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      hit_q <= 1'b0;
    end else if (clear_i) begin
      hit_q <= 1'b0;
    end else if (visit_i) begin
      hit_q <= in_range;  // reflects the last visited node
    end
  end

  always_ff @(posedge clk_i) begin
    if (visit_i && in_range) begin
      new_q.addr       <= free_addr_i;
      new_q.size       <= '0;  // not written, size stays in memory
      new_q.next_addr  <= node_i.next_addr;
      link_q           <= node_i;
      link_q.next_addr <= free_addr_i;
    end
  end

  assign hit_o      = hit_q;
  assign new_hdr_o  = new_q;
  assign link_hdr_o = link_q;

  // a hit left over from an earlier request would name a stale address
  a_clear_hit : assert property (@(posedge clk_i) disable iff (!rst_ni)
    hit_o |-> new_hdr_o.addr == free_addr_i);

endmodule

`default_nettype wire

// File: design/heap_alloc_top.sv
`timescale 1ns/1ns
`default_nettype none

module heap_alloc_top
  import heap_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_valid_i,
  input  logic              is_alloc_i,
  input  logic [DATA_W-1:0] size_i,
  input  logic [DATA_W-1:0] addr_i,
  output logic              ready_o,
  input  logic              lsu_ready_i,
  input  header_rsp_t       lsu_rsp_i,
  output header_req_t       lsu_req_o
);

  logic              clear, visit;
  header_t           node, pred;
  logic [DATA_W-1:0] req_size, free_addr;
  logic              fit_found, fit_split;
  header_t           fit_alloc_hdr, fit_split_hdr, fit_link_hdr;
  logic              slot_hit;
  header_t           slot_new_hdr, slot_link_hdr;

  list_walker u_walker (
    .clk_i, .rst_ni, .req_valid_i, .is_alloc_i, .size_i, .addr_i, .ready_o,
    .lsu_ready_i, .lsu_rsp_i, .lsu_req_o,
    .clear_o(clear), .visit_o(visit), .node_o(node), .pred_o(pred),
    .req_size_o(req_size), .free_addr_o(free_addr),
    .fit_found_i(fit_found), .fit_split_i(fit_split), .fit_alloc_hdr_i(fit_alloc_hdr),
    .fit_split_hdr_i(fit_split_hdr), .fit_link_hdr_i(fit_link_hdr),
    .slot_hit_i(slot_hit), .slot_new_hdr_i(slot_new_hdr), .slot_link_hdr_i(slot_link_hdr)
  );

  best_fit_tracker u_fit (
    .clk_i, .rst_ni, .clear_i(clear), .visit_i(visit), .node_i(node), .pred_i(pred),
    .req_size_i(req_size), .found_o(fit_found), .do_split_o(fit_split),
    .alloc_hdr_o(fit_alloc_hdr), .split_hdr_o(fit_split_hdr), .link_hdr_o(fit_link_hdr)
  );

  free_slot_finder u_slot (
    .clk_i, .rst_ni, .clear_i(clear), .visit_i(visit), .node_i(node),
    .free_addr_i(free_addr), .hit_o(slot_hit),
    .new_hdr_o(slot_new_hdr), .link_hdr_o(slot_link_hdr)
  );

endmodule

`default_nettype wire

// File: tb/tb_heap_alloc.sv
`timescale 1ns/1ns
`default_nettype none

module tb_heap_alloc
  import heap_pkg::*;
();

  localparam int N_OPS = 34;  // directed plus random operations

  logic              clk, rst_n, req_valid, is_alloc, ready, lsu_ready;
  logic [DATA_W-1:0] size, addr;
  header_rsp_t       lsu_rsp;
  header_req_t       lsu_req;

  logic [31:0]       lfsr_q = 32'hc096_0bae;
  header_t           mem [logic [DATA_W-1:0]];  // lsu backing store
  header_req_t       seen_q[$], exp_q[$];
  logic [DATA_W-1:0] fl_addr[$], fl_size[$];    // model free list, sorted
  logic [DATA_W-1:0] al_addr[$], al_size[$];    // blocks handed out
  int                n_checks, n_errors, n_tests;

  heap_alloc_top UUT (
    .clk_i(clk), .rst_ni(rst_n), .req_valid_i(req_valid), .is_alloc_i(is_alloc),
    .size_i(size), .addr_i(addr), .ready_o(ready),
    .lsu_ready_i(lsu_ready), .lsu_rsp_i(lsu_rsp), .lsu_req_o(lsu_req)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin : watchdog
    repeat (400 * N_OPS + 20) @(posedge clk);
    $display("watchdog expired, the run did not finish within %0d cycles", 400 * N_OPS);
    $display("TEST FAIL");
    $finish;
  end

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  task automatic check_value(input string name, input logic [95:0] got, input logic [95:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  function automatic header_t serve_lsu(input header_req_t r);
    header_t h;
    h = r.header;
    case (r.lsu_op)
      LOAD: begin
        if (mem.exists(r.header.addr)) begin
          h = mem[r.header.addr];
        end else begin
          n_errors++;
          $display("LOAD of address %h which holds no header", r.header.addr);
        end
      end
      EDIT_NEXT_ADDR: begin
        if (mem.exists(r.header.addr)) h = mem[r.header.addr];
        h.next_addr = r.header.next_addr;  // size stays as stored
        mem[r.header.addr] = h;
      end
      EDIT_SIZE_AND_NEXT_ADDR: mem[r.header.addr] = r.header;
      default: ;
    endcase
    return h;
  endfunction

  initial begin : lsu_model
    header_req_t r;
    logic        accept;
    logic        stalled;
    logic [31:0] delay;
    lsu_ready = 1'b0;
    lsu_rsp   = '0;
    stalled   = 1'b0;
    forever begin
      @(negedge clk);
      if (stalled) begin  // request held under back-pressure
        check_value("lsu_req_o.val", 96'(lsu_req.val), 96'(1'b1));
        check_value("lsu_req_o.lsu_op", 96'(lsu_req.lsu_op), 96'(r.lsu_op));
        check_value("lsu_req_o.header", lsu_req.header, r.header);
      end
      accept  = rst_n && lsu_req.val && lsu_ready;  // taken at the coming edge
      stalled = rst_n && lsu_req.val && !lsu_ready;
      r       = lsu_req;
      @(posedge clk);
      #2;
      if (accept) begin
        seen_q.push_back(r);
        lsu_ready = 1'b0;
        delay     = rand_bits(2);
        repeat (delay) begin
          @(posedge clk);
          #2;
        end
        lsu_rsp.val    = 1'b1;
        lsu_rsp.header = serve_lsu(r);
        @(posedge clk);
        #2;
        lsu_rsp = '0;
      end
      delay     = rand_bits(2);
      lsu_ready = (delay != 0);  // low about one cycle in four
    end
  end

  function automatic void expect_req(input lsu_op_e op, input logic [DATA_W-1:0] a,
                                     input logic [DATA_W-1:0] s, input logic [DATA_W-1:0] n);
    header_req_t r;
    r        = '0;
    r.val    = 1'b1;
    r.lsu_op = op;
    r.header = '{a, s, n};
    exp_q.push_back(r);
  endfunction

  // only the fields the lsu acts on
  function automatic header_t relevant(input header_req_t r);
    header_t h;
    h = r.header;
    case (r.lsu_op)
      LOAD: begin
        h.size      = '0;
        h.next_addr = '0;
      end
      EDIT_NEXT_ADDR:          h.size = '0;
      EDIT_SIZE_AND_NEXT_ADDR: ;
      default:                 h = '0;
    endcase
    return h;
  endfunction

  function automatic void predict_alloc(input logic [DATA_W-1:0] sz);
    int                best;
    logic [DATA_W-1:0] left, nxt, link;
    best = -1;
    exp_q.delete();
    expect_req(LOCK, '0, '0, '0);
    for (int i = 0; i < fl_addr.size(); i++) begin
      expect_req(LOAD, fl_addr[i], '0, '0);
      if (fl_size[i] >= sz && (best < 0 || fl_size[i] - sz < fl_size[best] - sz)) best = i;
    end
    if (best > 0) begin
      left = fl_size[best] - sz;
      nxt  = (best + 1 < fl_addr.size()) ? fl_addr[best + 1] : '0;
      link = nxt;
      expect_req(EDIT_SIZE_AND_NEXT_ADDR, fl_addr[best], sz, '0);
      al_addr.push_back(fl_addr[best]);
      al_size.push_back(sz);
      if (left >= MIN_ALLOC_SIZE) begin
        link = fl_addr[best] + BLOCK_HEADER_SIZE + sz;
        expect_req(EDIT_SIZE_AND_NEXT_ADDR, link, left - BLOCK_HEADER_SIZE, nxt);
        fl_addr[best] = link;
        fl_size[best] = left - BLOCK_HEADER_SIZE;
      end else begin
        fl_addr.delete(best);
        fl_size.delete(best);
      end
      expect_req(EDIT_NEXT_ADDR, fl_addr[best - 1], '0, link);
    end
    expect_req(UNLOCK, '0, '0, '0);
  endfunction

  function automatic logic [DATA_W-1:0] predict_free(input int j);
    logic [DATA_W-1:0] a, nxt;
    a = al_addr[j];
    exp_q.delete();
    expect_req(LOCK, '0, '0, '0);
    for (int i = 0; i < fl_addr.size(); i++) begin
      nxt = (i + 1 < fl_addr.size()) ? fl_addr[i + 1] : '0;
      expect_req(LOAD, fl_addr[i], '0, '0);
      if (fl_addr[i] < a && (nxt == '0 || a < nxt)) begin
        expect_req(EDIT_NEXT_ADDR, a, '0, nxt);
        expect_req(EDIT_NEXT_ADDR, fl_addr[i], '0, a);
        fl_addr.insert(i + 1, a);
        fl_size.insert(i + 1, al_size[j]);
        break;
      end
    end
    al_addr.delete(j);
    al_size.delete(j);
    expect_req(UNLOCK, '0, '0, '0);
    return a;
  endfunction

  task automatic run_op(input logic alloc, input logic [DATA_W-1:0] sz,
                        input logic [DATA_W-1:0] a);
    seen_q.delete();
    @(posedge clk);
    #2;
    req_valid = 1'b1;
    is_alloc  = alloc;
    size      = sz;
    addr      = a;
    @(posedge clk);  // taken, core was idle
    #2;
    req_valid = 1'b0;
    @(negedge clk);
    check_value("lsu_req_o.val", 96'(lsu_req.val), 96'(1'b1));
    check_value("lsu_req_o.lsu_op", 96'(lsu_req.lsu_op), 96'(LOCK));
    while (!ready) @(negedge clk);
    check_value("request count", 96'(seen_q.size()), 96'(exp_q.size()));
    for (int i = 0; i < exp_q.size() && i < seen_q.size(); i++) begin
      check_value("lsu_req_o.lsu_op", 96'(seen_q[i].lsu_op), 96'(exp_q[i].lsu_op));
      check_value("lsu_req_o.header", relevant(seen_q[i]), relevant(exp_q[i]));
    end
  endtask

  task automatic do_alloc(input logic [DATA_W-1:0] sz);
    predict_alloc(sz);
    run_op(1'b1, sz, '0);
  endtask

  task automatic do_free(input int j);
    logic [DATA_W-1:0] a;
    a = predict_free(j);
    run_op(1'b0, '0, a);
  endtask

  function automatic int count_writes();
    int n;
    n = 0;
    foreach (seen_q[i]) begin
      if (seen_q[i].lsu_op inside {EDIT_NEXT_ADDR, EDIT_SIZE_AND_NEXT_ADDR}) n++;
    end
    return n;
  endfunction

  task automatic add_block(input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] s,
                           input logic [DATA_W-1:0] n);
    mem[a] = '{a, s, n};
    fl_addr.push_back(a);
    fl_size.push_back(s);
  endtask

  task automatic report_test(input string name);
    n_tests++;
    $display("test %0d %s done, %0d errors so far", n_tests, name, n_errors);
  endtask

  initial begin : stimulus
    header_t           h;
    logic [DATA_W-1:0] a, r;
    int                steps;
    rst_n     = 1'b0;
    req_valid = 1'b0;
    is_alloc  = 1'b0;
    size      = '0;
    addr      = '0;
    n_checks  = 0;
    n_errors  = 0;
    n_tests   = 0;
    add_block(HEAD_ADDR, 0, 'h100);
    add_block('h100, 200, 'h400);
    add_block('h400, 96, 'h800);
    add_block('h800, 500, 'h1000);
    add_block('h1000, 64, '0);
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(negedge clk);
    check_value("ready_o", 96'(ready), 96'(1'b1));
    check_value("lsu_req_o.val", 96'(lsu_req.val), 96'(1'b0));
    report_test("reset");

    do_alloc(40);  // 0x1000 leaves 24
    check_value("write count", 96'(count_writes()), 96'(2));
    report_test("alloc_no_split");
    do_alloc(50);  // 0x400 leaves 46
    check_value("write count", 96'(count_writes()), 96'(3));
    report_test("alloc_split");
    do_alloc(1000);
    check_value("write count", 96'(count_writes()), 96'(0));
    report_test("alloc_no_fit");
    do_free(0);  // 0x1000 goes back behind 0x800
    check_value("write count", 96'(count_writes()), 96'(2));
    report_test("free_insert");

    for (int k = 0; k < 30; k++) begin
      r = rand_bits(1);
      if (al_addr.size() == 0 || r[0]) begin
        r = rand_bits(7);
        do_alloc(r + 1);
      end else begin
        r = rand_bits(5);
        do_free(int'(r) % al_addr.size());
      end
    end
    report_test("random_mix");

    // walk memory from the head and compare with the model
    a     = HEAD_ADDR;
    steps = 0;
    while (a != '0 && steps < 64) begin
      if (!mem.exists(a)) begin
        n_errors++;
        $display("final walk reached address %h which holds no header", a);
        break;
      end
      h = mem[a];
      if (steps < fl_addr.size()) begin
        check_value("list addr", 96'(h.addr), 96'(fl_addr[steps]));
        check_value("list size", 96'(h.size), 96'(fl_size[steps]));
      end
      a = h.next_addr;
      steps++;
    end
    check_value("list length", 96'(steps), 96'(fl_addr.size()));
    report_test("final_list");

    $display("summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: heap_alloc.f
design/heap_pkg.sv
design/list_walker.sv
design/best_fit_tracker.sv
design/free_slot_finder.sv
design/heap_alloc_top.sv
tb/tb_heap_alloc.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the heap allocator testbench with Verilator and runs it
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  -f heap_alloc.f \
  --top-module tb_heap_alloc \
  -o sim_heap_alloc

./obj_dir/sim_heap_alloc | tee sim.log

if grep -q "TEST FAIL" sim.log; then
  echo "simulation reported a failure, see sim.log"
  exit 1
fi
echo "simulation finished without a reported failure"
